// ==== dv/arc_interp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arc_interp_tb;

	import cmd_pkg::*;
	import motion_pkg::*;

	localparam int POS_BITS     = 10;
	localparam int STEP_PERIOD  = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS    = 10;
	localparam int RMAX         = 57;   // random offsets stay within +-40
	localparam int MAX_STEPS    = 1024;
	localparam int SEED         = 21307;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 +
		NUM_TESTS * (POS_BITS + 1 + STEP_PERIOD * (8 * RMAX + 9) + 20);

	typedef logic signed [POS_BITS-1:0] coord_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        start;
	rot_t        rot;
	coord_t      start_x, start_y;
	coord_t      end_x, end_y;
	coord_t      ctr_i, ctr_j;
	logic        step_x, step_y;
	logic        dir_x, dir_y;
	coord_t      pos_x, pos_y;
	logic        busy;
	logic        done;
	end_reason_t reason;

	// expected walk filled by ref_arc before each start
	step_dir_t   exp_dir [MAX_STEPS];
	int          exp_px [MAX_STEPS];
	int          exp_py [MAX_STEPS];
	int          exp_count;
	end_reason_t exp_reason;

	// monitor state
	int          cyc = 0;
	int          arcs_done = 0;
	bit          in_arc = 1'b0;
	bit          pos_pending = 1'b0;
	int          start_cyc;
	int          last_step_cyc;
	int          step_idx;
	int          last_count;
	end_reason_t last_reason;
	step_dir_t   seen_dir;

	int          sx, sy, ex, ey, ci, cj, k, full_n, lim;
	rot_t        rv;

	arc_interp_top #(
		.POS_BITS    (POS_BITS),
		.STEP_PERIOD (STEP_PERIOD)
	) arc_interp_top_i (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.rot     (rot),
		.start_x (start_x),
		.start_y (start_y),
		.end_x   (end_x),
		.end_y   (end_y),
		.ctr_i   (ctr_i),
		.ctr_j   (ctr_j),
		.step_x  (step_x),
		.step_y  (step_y),
		.dir_x   (dir_x),
		.dir_y   (dir_y),
		.pos_x   (pos_x),
		.pos_y   (pos_y),
		.busy    (busy),
		.done    (done),
		.reason  (reason)
	);

	always #10 clk = ~clk;              // 20 ns period

	always @(posedge clk) cyc <= cyc + 1;

	task automatic check_val(input string what, input int got, input int expected);
		if (got != expected) begin
			$display("Error at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
			$display("Result: FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference arc walk
	////////////////////////////////////////////////////////////////////////////

	function automatic int isqrt_floor(input int v);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= v)
			r = r + 1;
		return r;
	endfunction

	function automatic quadrant_t quad_of(input int x, input int y);
		if (x > 0 && y >= 0)
			return Q1;
		else if (x <= 0 && y > 0)
			return Q2;
		else if (x < 0 && y <= 0)
			return Q3;
		else if (x >= 0 && y < 0)
			return Q4;
		return Q1;                          // centre
	endfunction

	function automatic step_dir_t move_for(input rot_t rot_v, input quadrant_t q,
		input bit out_move);
		step_dir_t m;
		if (rot_v == ROT_CCW) begin
			case (q)
				Q1: m = out_move ? STEP_YP : STEP_XN;
				Q2: m = out_move ? STEP_XN : STEP_YN;
				Q3: m = out_move ? STEP_YN : STEP_XP;
				default: m = out_move ? STEP_XP : STEP_YP;
			endcase
		end else begin
			case (q)
				Q1: m = out_move ? STEP_XP : STEP_YN;
				Q2: m = out_move ? STEP_YP : STEP_XP;
				Q3: m = out_move ? STEP_XN : STEP_YP;
				default: m = out_move ? STEP_YN : STEP_XN;
			endcase
		end
		return m;
	endfunction

	// returns the step count and leaves the walk in the exp_ arrays
	function automatic int ref_arc(input rot_t rot_v, input int sx_v, input int sy_v,
		input int ex_v, input int ey_v, input int ci_v, input int cj_v);
		int cx, cy, x, y, tx, ty, r2, lim_v, n;
		bit stop;
		step_dir_t m;
		cx = sx_v + ci_v;
		cy = sy_v + cj_v;
		x = -ci_v;
		y = -cj_v;
		tx = ex_v - cx;
		ty = ey_v - cy;
		r2 = ci_v * ci_v + cj_v * cj_v;
		lim_v = 8 * isqrt_floor(r2) + 8;
		n = 0;
		stop = 1'b0;
		while (!stop) begin
			m = move_for(rot_v, quad_of(x, y), (x * x + y * y) <= r2);
			case (m)
				STEP_XP: x = x + 1;
				STEP_XN: x = x - 1;
				STEP_YP: y = y + 1;
				default: y = y - 1;
			endcase
			exp_dir[n] = m;
			exp_px[n] = cx + x;
			exp_py[n] = cy + y;
			n = n + 1;
			if (x == tx && y == ty) begin
				exp_reason = END_REACHED;     // end point wins over the limit
				stop = 1'b1;
			end else if (n >= lim_v) begin
				exp_reason = END_LIMIT;
				stop = 1'b1;
			end
		end
		return n;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// monitor on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			if (pos_pending) begin
				check_val("pos_x after step", pos_x, exp_px[step_idx-1]);
				check_val("pos_y after step", pos_y, exp_py[step_idx-1]);
				pos_pending = 1'b0;
			end
			if (!in_arc) begin
				check_val("busy while idle", busy, 0);
				check_val("done while idle", done, 0);
				check_val("step_x while idle", step_x, 0);
				check_val("step_y while idle", step_y, 0);
				if (start) begin          // accepted since busy is low
					in_arc = 1'b1;
					start_cyc = cyc;
					step_idx = 0;
				end
			end else if (done) begin
				check_val("step count", step_idx, exp_count);
				check_val("done after last step", cyc - last_step_cyc, 1);
				check_val("busy with done", busy, 0);
				check_val("end reason", reason, exp_reason);
				last_count = step_idx;
				last_reason = reason;
				in_arc = 1'b0;
				arcs_done = arcs_done + 1;
			end else begin
				check_val("busy during arc", busy, 1);
				check_val("both axes strobed", step_x && step_y, 0);
				if (step_x || step_y) begin
					check_val("step beyond expected count", step_idx < exp_count, 1);
					if (step_x)
						seen_dir = dir_x ? STEP_XP : STEP_XN;
					else
						seen_dir = dir_y ? STEP_YP : STEP_YN;
					check_val("step direction", seen_dir, exp_dir[step_idx]);
					if (step_idx == 0)
						check_val("first step cycle", cyc - start_cyc,
							2 + POS_BITS + STEP_PERIOD);
					else
						check_val("step spacing", cyc - last_step_cyc, STEP_PERIOD);
					last_step_cyc = cyc;
					step_idx = step_idx + 1;
					pos_pending = 1'b1;
				end
			end
		end
	end

	// poke sends a second start while the arc is running
	task automatic run_arc(input rot_t rot_v, input int sx_v, input int sy_v,
		input int ex_v, input int ey_v, input int ci_v, input int cj_v, input bit poke);
		int target;
		exp_count = ref_arc(rot_v, sx_v, sy_v, ex_v, ey_v, ci_v, cj_v);
		target = arcs_done + 1;
		@(posedge clk);
		rot     <= rot_v;
		start_x <= coord_t'(sx_v);
		start_y <= coord_t'(sy_v);
		end_x   <= coord_t'(ex_v);
		end_y   <= coord_t'(ey_v);
		ctr_i   <= coord_t'(ci_v);
		ctr_j   <= coord_t'(cj_v);
		start   <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (poke) begin
			repeat (3) @(posedge clk);
			rot     <= (rot_v == ROT_CW) ? ROT_CCW : ROT_CW;
			start_x <= coord_t'(sx_v + 9);
			ctr_i   <= coord_t'(ci_v - 4);
			start   <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		while (arcs_done < target)
			@(posedge clk);
		repeat (4) @(posedge clk);           // idle gap with no strobe allowed
	endtask

	function automatic int rand_in(input int lo, input int hi);
		return lo + int'($urandom_range(hi - lo, 0));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		reset   = 1'b1;
		start   = 1'b0;
		rot     = ROT_CW;
		start_x = '0;
		start_y = '0;
		end_x   = '0;
		end_y   = '0;
		ctr_i   = '0;
		ctr_j   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		repeat (5) @(posedge clk);           // monitor checks the idle lows
		@(negedge clk);
		check_val("pos_x after reset", pos_x, 0);
		check_val("pos_y after reset", pos_y, 0);

		// ccw quarter from (10,0) to (0,10) around the origin
		run_arc(ROT_CCW, 10, 0, 0, 10, -10, 0, 1'b0);
		check_val("quarter arc reason", last_reason, END_REACHED);
		check_val("quarter arc pos_x", pos_x, 0);
		check_val("quarter arc pos_y", pos_y, 10);

		// cw quarter around (100,50)
		run_arc(ROT_CW, 100, 65, 115, 50, 0, -15, 1'b0);

		// random arcs ending on their own path
		repeat (6) begin
			rv = ($urandom_range(1, 0) == 1) ? ROT_CCW : ROT_CW;
			sx = rand_in(-150, 150);
			sy = rand_in(-150, 150);
			ci = rand_in(-40, 40);
			cj = rand_in(-40, 40);
			if (ci == 0 && cj == 0)
				cj = 7;
			full_n = ref_arc(rv, sx, sy, sx, sy, ci, cj);
			k = rand_in(0, full_n - 1);
			ex = exp_px[k];
			ey = exp_py[k];
			run_arc(rv, sx, sy, ex, ey, ci, cj, 1'b0);
		end

		// full circle with end equal to start
		run_arc(ROT_CCW, -50, 40, -50, 40, -10, 0, 1'b0);
		check_val("full circle reason", last_reason, END_REACHED);
		check_val("full circle pos_x", pos_x, -50);
		check_val("full circle pos_y", pos_y, 40);

		// end off the circle runs into the step limit
		lim = 8 * isqrt_floor(7 * 7 + 3 * 3) + 8;
		run_arc(ROT_CW, 20, -30, 80, 30, -7, -3, 1'b1);
		check_val("limit arc reason", last_reason, END_LIMIT);
		check_val("limit arc step count", last_count, lim);

		$display("Result: PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired: the simulation hung after %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

endmodule : arc_interp_tb

`default_nettype wire

// ==== rtl/arc_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module arc_fsm (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  sqrt_done,
	input  logic                  tick,
	input  logic                  at_end,
	input  logic                  limit_hit,
	output logic                  busy,
	output logic                  load,
	output logic                  sqrt_go,
	output logic                  run_pace,
	output logic                  step,
	output logic                  done,
	output cmd_pkg::end_reason_t  reason
);

	import cmd_pkg::*;

	// FINISH is the cycle right after a step, when position and count are settled
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		ROOT,
		WALK,
		FINISH
	} state_t;

	state_t state;
	state_t state_nxt;

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	// end point or step limit seen one cycle after the step
	assign done = (state == FINISH) && (at_end || limit_hit);
	assign busy = (state != IDLE) && !done;
	assign load = start && !busy;        // start dropped while busy
	assign sqrt_go = (state == LOAD);
	assign step = (state == WALK) && tick;

	// pacing starts together with sqrt_done, stays on across FINISH
	assign run_pace = (state == WALK) || (state == FINISH) ||
		((state == ROOT) && sqrt_done);

	// reaching the end point wins over the limit
	assign reason = at_end ? END_REACHED : END_LIMIT;

	////////////////////////////////////////////////////////////////////////////
	// state sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start)
					state_nxt = LOAD;
			end
			LOAD: state_nxt = ROOT;       // operands latched, kick the root
			ROOT: begin
				if (sqrt_done)
					state_nxt = WALK;
			end
			WALK: begin
				if (tick)
					state_nxt = FINISH;
			end
			FINISH: begin
				if (!done)
					state_nxt = WALK;
				else if (start)
					state_nxt = LOAD;       // busy already low here
				else
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_nxt;
	end

endmodule : arc_fsm

`default_nettype wire

// ==== rtl/arc_interp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arc_interp_top #(
	parameter int POS_BITS    = 10,
	parameter int STEP_PERIOD = 4 // at least 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  cmd_pkg::rot_t              rot,
	input  logic signed [POS_BITS-1:0] start_x,
	input  logic signed [POS_BITS-1:0] start_y,
	input  logic signed [POS_BITS-1:0] end_x,
	input  logic signed [POS_BITS-1:0] end_y,
	input  logic signed [POS_BITS-1:0] ctr_i,
	input  logic signed [POS_BITS-1:0] ctr_j,
	output logic                       step_x,
	output logic                       step_y,
	output logic                       dir_x,
	output logic                       dir_y,
	output logic signed [POS_BITS-1:0] pos_x,
	output logic signed [POS_BITS-1:0] pos_y,
	output logic                       busy,
	output logic                       done,
	output cmd_pkg::end_reason_t       reason
);

	logic                  load;
	logic                  sqrt_go;
	logic                  sqrt_done;
	logic                  run_pace;
	logic                  tick;
	logic                  step;
	logic                  at_end;
	logic                  limit_hit;
	logic [2*POS_BITS+1:0] radicand;
	logic [POS_BITS:0]     root;

	arc_fsm arc_fsm_i (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.sqrt_done (sqrt_done),
		.tick      (tick),
		.at_end    (at_end),
		.limit_hit (limit_hit),
		.busy      (busy),
		.load      (load),
		.sqrt_go   (sqrt_go),
		.run_pace  (run_pace),
		.step      (step),
		.done      (done),
		.reason    (reason)
	);

	step_pacer #(
		.POS_BITS    (POS_BITS),
		.STEP_PERIOD (STEP_PERIOD)
	) step_pacer_i (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.run_pace  (run_pace),
		.root      (root),
		.step      (step),
		.tick      (tick),
		.limit_hit (limit_hit)
	);

	int_sqrt #(
		.POS_BITS (POS_BITS)
	) int_sqrt_i (
		.clk       (clk),
		.reset     (reset),
		.sqrt_go   (sqrt_go),
		.radicand  (radicand),
		.root      (root),
		.sqrt_done (sqrt_done)
	);

	arc_stepper #(
		.POS_BITS (POS_BITS)
	) arc_stepper_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.step     (step),
		.rot      (rot),
		.start_x  (start_x),
		.start_y  (start_y),
		.end_x    (end_x),
		.end_y    (end_y),
		.ctr_i    (ctr_i),
		.ctr_j    (ctr_j),
		.radicand (radicand),
		.step_x   (step_x),
		.step_y   (step_y),
		.dir_x    (dir_x),
		.dir_y    (dir_y),
		.pos_x    (pos_x),
		.pos_y    (pos_y),
		.at_end   (at_end)
	);

endmodule : arc_interp_top

`default_nettype wire

// ==== rtl/arc_stepper.sv ====
`timescale 1ns/1ps
`default_nettype none

module arc_stepper #(
	parameter int POS_BITS = 10
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load,
	input  logic                       step,
	input  cmd_pkg::rot_t              rot,
	input  logic signed [POS_BITS-1:0] start_x,
	input  logic signed [POS_BITS-1:0] start_y,
	input  logic signed [POS_BITS-1:0] end_x,
	input  logic signed [POS_BITS-1:0] end_y,
	input  logic signed [POS_BITS-1:0] ctr_i,
	input  logic signed [POS_BITS-1:0] ctr_j,
	output logic [2*POS_BITS+1:0]      radicand,
	output logic                       step_x,
	output logic                       step_y,
	output logic                       dir_x,
	output logic                       dir_y,
	output logic signed [POS_BITS-1:0] pos_x,
	output logic signed [POS_BITS-1:0] pos_y,
	output logic                       at_end
);

	import cmd_pkg::*;
	import motion_pkg::*;

	localparam int RB = POS_BITS + 1;   // relative coordinates
	localparam int SB = 2*POS_BITS + 2; // squared radii
	localparam logic signed [RB-1:0] ONE = 1;

	logic signed [RB-1:0] cen_x, cen_y;
	logic signed [RB-1:0] rel_x, rel_y;
	logic signed [RB-1:0] end_rx, end_ry;
	logic [SB-1:0]        r2;
	rot_t                 rot_r;

	logic signed [RB-1:0] ld_cx, ld_cy;
	logic signed [RB-1:0] ld_sx, ld_sy;
	logic [SB-1:0]        c2;
	logic                 go_out;
	quadrant_t            quad;
	step_dir_t            dir;
	logic signed [RB-1:0] nxt_x, nxt_y;
	logic signed [RB-1:0] abs_x, abs_y;

	function automatic logic [SB-1:0] square(input logic signed [RB-1:0] v);
		logic signed [2*RB-1:0] p;
		p = v * v;
		return p;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// step choice
	////////////////////////////////////////////////////////////////////////////

	assign ld_cx = start_x + ctr_i;     // centre, absolute
	assign ld_cy = start_y + ctr_j;
	assign ld_sx = -ctr_i;              // start relative to centre
	assign ld_sy = -ctr_j;

	assign radicand = r2;
	assign c2 = square(rel_x) + square(rel_y);
	assign go_out = (c2 <= r2);         // inside or on the circle
	assign at_end = (rel_x == end_rx) && (rel_y == end_ry);

	always_comb begin
		if (rel_x > 0 && rel_y >= 0)
			quad = Q1;
		else if (rel_x <= 0 && rel_y > 0)
			quad = Q2;
		else if (rel_x < 0 && rel_y <= 0)
			quad = Q3;
		else if (rel_y < 0)
			quad = Q4;
		else
			quad = Q1; // centre
	end

	always_comb begin
		if (rot_r == ROT_CCW) begin
			case (quad)
				Q1: dir = go_out ? STEP_YP : STEP_XN;
				Q2: dir = go_out ? STEP_XN : STEP_YN;
				Q3: dir = go_out ? STEP_YN : STEP_XP;
				default: dir = go_out ? STEP_XP : STEP_YP; // Q4
			endcase
		end else begin
			case (quad)
				Q1: dir = go_out ? STEP_XP : STEP_YN;
				Q2: dir = go_out ? STEP_YP : STEP_XP;
				Q3: dir = go_out ? STEP_XN : STEP_YP;
				default: dir = go_out ? STEP_YN : STEP_XN; // Q4
			endcase
		end
	end

	always_comb begin
		nxt_x = rel_x;
		nxt_y = rel_y;
		case (dir)
			STEP_XP: nxt_x = rel_x + ONE;
			STEP_XN: nxt_x = rel_x - ONE;
			STEP_YP: nxt_y = rel_y + ONE;
			default: nxt_y = rel_y - ONE;
		endcase
	end

	assign abs_x = cen_x + nxt_x;
	assign abs_y = cen_y + nxt_y;

	// motor strobes go out with the step itself
	assign step_x = step && (dir == STEP_XP || dir == STEP_XN);
	assign step_y = step && (dir == STEP_YP || dir == STEP_YN);
	assign dir_x  = (dir == STEP_XP);
	assign dir_y  = (dir == STEP_YP);

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pos_x <= '0;
			pos_y <= '0;
		end else if (load) begin
			pos_x <= start_x;
			pos_y <= start_y;
		end else if (step) begin
			pos_x <= abs_x[POS_BITS-1:0];
			pos_y <= abs_y[POS_BITS-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cen_x  <= ld_cx;
			cen_y  <= ld_cy;
			rel_x  <= ld_sx;
			rel_y  <= ld_sy;
			end_rx <= end_x - ld_cx;
			end_ry <= end_y - ld_cy;
			r2     <= square(ld_sx) + square(ld_sy);
			rot_r  <= rot;
		end else if (step) begin
			rel_x <= nxt_x;
			rel_y <= nxt_y;
		end
	end

endmodule : arc_stepper

`default_nettype wire

// ==== rtl/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// arc command level
	////////////////////////////////////////////////////////////////////////////

	// rotation sense of the arc command
	typedef enum logic {
		ROT_CW  = 1'b0, // G02
		ROT_CCW = 1'b1  // G03
	} rot_t;

	// why the walk stopped, reported along with done
	typedef enum logic {
		END_REACHED = 1'b0, // landed on the end point
		END_LIMIT   = 1'b1  // ran out of steps
	} end_reason_t;

endpackage : cmd_pkg

`default_nettype wire

// ==== rtl/int_sqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_sqrt #(
	parameter int POS_BITS = 10
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sqrt_go,
	input  logic [2*POS_BITS+1:0] radicand,
	output logic [POS_BITS:0]     root,
	output logic                  sqrt_done
);

	localparam int NB = 2*POS_BITS + 2; // radicand bits
	localparam int QB = POS_BITS + 1;   // root bits, one per iteration
	localparam int RW = POS_BITS + 4;   // partial remainder
	localparam int CW = $clog2(POS_BITS + 1);

	logic [NB-1:0] rad;
	logic [NB-1:0] cur_rad;
	logic [RW-1:0] rem;
	logic [RW-1:0] cur_rem;
	logic [RW-1:0] shifted;
	logic [RW-1:0] rem_nxt;
	logic [RW:0]   trial;
	logic [QB-1:0] cur_root;
	logic [QB-1:0] root_nxt;
	logic [CW-1:0] left;
	logic          running;

	// first iteration runs in the sqrt_go cycle straight off the inputs
	assign cur_rad  = sqrt_go ? radicand : rad;
	assign cur_rem  = sqrt_go ? '0 : rem;
	assign cur_root = sqrt_go ? '0 : root;

	// bring down the next two bits and try subtracting 4*root+1
	assign shifted = {cur_rem[RW-3:0], cur_rad[NB-1 -: 2]};
	assign trial   = {1'b0, shifted} - {1'b0, RW'({cur_root, 2'b01})};

	always_comb begin
		if (trial[RW]) begin // negative, restore
			rem_nxt  = shifted;
			root_nxt = {cur_root[QB-2:0], 1'b0};
		end else begin
			rem_nxt  = trial[RW-1:0];
			root_nxt = {cur_root[QB-2:0], 1'b1};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running   <= 1'b0;
			left      <= '0;
			sqrt_done <= 1'b0;
		end else begin
			sqrt_done <= 1'b0;
			if (sqrt_go) begin
				running <= 1'b1;
				left    <= CW'(POS_BITS);     // iterations still to go
			end else if (running) begin
				left <= left - CW'(1);
				if (left == CW'(1)) begin
					running   <= 1'b0;
					sqrt_done <= 1'b1;
				end
			end
		end
	end

	// datapath, root holds once running drops
	always_ff @(posedge clk) begin
		if (sqrt_go || running) begin
			rad  <= cur_rad << 2;
			rem  <= rem_nxt;
			root <= root_nxt;
		end
	end

endmodule : int_sqrt

`default_nettype wire

// ==== rtl/motion_pkg.sv ====
`default_nettype none

package motion_pkg;

	////////////////////////////////////////////////////////////////////////////
	// geometry relative to the arc centre
	////////////////////////////////////////////////////////////////////////////

	// Q1 x>0 y>=0, Q2 x<=0 y>0, Q3 x<0 y<=0, Q4 x>=0 y<0
	// the centre itself is treated as Q1
	typedef enum logic [1:0] {
		Q1 = 2'd0,
		Q2 = 2'd1,
		Q3 = 2'd2,
		Q4 = 2'd3
	} quadrant_t;

	// single axis move, bit 1 picks the axis, bit 0 the negative sense
	typedef enum logic [1:0] {
		STEP_XP = 2'd0,
		STEP_XN = 2'd1,
		STEP_YP = 2'd2,
		STEP_YN = 2'd3
	} step_dir_t;

endpackage : motion_pkg

`default_nettype wire

// ==== rtl/step_pacer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_pacer #(
	parameter int POS_BITS    = 10,
	parameter int STEP_PERIOD = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              load,
	input  logic              run_pace,
	input  logic [POS_BITS:0] root,
	input  logic              step,
	output logic              tick,
	output logic              limit_hit
);

	localparam int PB = $clog2(STEP_PERIOD + 1);
	localparam int CB = POS_BITS + 5;   // room for 8*r+8

	logic [PB-1:0] phase;
	logic [CB-1:0] steps;
	logic [CB-1:0] limit;

	////////////////////////////////////////////////////////////////////////////
	// step period
	////////////////////////////////////////////////////////////////////////////

	// phase sits at 0 while idle, so each rise of run_pace restarts it
	assign tick = run_pace && (phase == PB'(STEP_PERIOD));

	always_ff @(posedge clk) begin
		if (reset)
			phase <= '0;
		else if (!run_pace)
			phase <= '0;
		else if (tick)
			phase <= PB'(1);               // counts 1..STEP_PERIOD
		else
			phase <= phase + PB'(1);
	end

	////////////////////////////////////////////////////////////////////////////
	// step limit
	////////////////////////////////////////////////////////////////////////////

	assign limit = CB'({root, 3'b000}) + CB'(8);
	assign limit_hit = (steps >= limit);

	always_ff @(posedge clk) begin
		if (reset)
			steps <= '0;
		else if (load)
			steps <= '0;                  // new arc
		else if (step)
			steps <= steps + CB'(1);
	end

endmodule : step_pacer

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the arc interpolator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module arc_interp_tb -f tb.f -o sim_arc
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_arc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1

// ==== tb.f ====
rtl/cmd_pkg.sv
rtl/motion_pkg.sv
rtl/int_sqrt.sv
rtl/step_pacer.sv
rtl/arc_stepper.sv
rtl/arc_fsm.sv
rtl/arc_interp_top.sv
dv/arc_interp_tb.sv
